/* hw/m6502_pkg.sv */
`default_nettype none

package m6502_pkg;

    // supported opcodes
    localparam logic [7:0] OP_NOP     = 8'hEA;
    localparam logic [7:0] OP_LDA_IMM = 8'hA9;
    localparam logic [7:0] OP_LDX_IMM = 8'hA2;
    localparam logic [7:0] OP_LDY_IMM = 8'hA0;
    localparam logic [7:0] OP_STA_ABS = 8'h8D;
    localparam logic [7:0] OP_STX_ABS = 8'h8E;
    localparam logic [7:0] OP_STY_ABS = 8'h8C;
    localparam logic [7:0] OP_JMP_ABS = 8'h4C;

    // aaa field, operation within a group
    localparam logic [2:0] AAA_LOAD  = 3'b101;
    localparam logic [2:0] AAA_STORE = 3'b100;

    // cc field, which register the group works on
    localparam logic [1:0] CC_A = 2'b01;
    localparam logic [1:0] CC_X = 2'b10;
    localparam logic [1:0] CC_Y = 2'b00;

    // bbb field, addressing mode
    localparam logic [2:0] BBB_ABS    = 3'b011;
    localparam logic [2:0] BBB_IMM_A  = 3'b010;  // immediate in the cc=01 group
    localparam logic [2:0] BBB_IMM_XY = 3'b000;  // immediate for LDX / LDY

    // two bytes, low byte first
    localparam logic [15:0] RESET_VECTOR = 16'hFFFC;

    // One opcode byte seen either whole (exact matches such as JMP)
    // or split into the aaa-bbb-cc fields for grouped decode.
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] aaa;
            logic [2:0] bbb;
            logic [1:0] cc;
        } f;
    } opcode_u;

endpackage

`default_nettype wire

/* hw/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

    // output port window, 16 bytes at D000
    localparam logic [15:0] IO_BASE = 16'hD000;
    localparam logic [15:0] IO_MASK = 16'hFFF0;

    // port index taken from the low address bits
    localparam int IO_INDEX_BITS = 4;

endpackage

`default_nettype wire

/* hw/mem_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_bus_if;

    logic [15:0] addr;   // driven by the core
    logic        rw;     // 1 = read, 0 = write
    logic [7:0]  wdata;  // write data from the core
    logic [7:0]  rdata;  // read data, valid in the same cycle

    modport master (
        output addr,
        output rw,
        output wdata,
        input  rdata
    );

    modport target_rd (
        input  addr,
        output rdata
    );

    modport target_wr (
        input  addr,
        input  rw,
        input  wdata
    );

endinterface

`default_nettype wire

/* hw/program_store.sv */
`timescale 1ns/10ps
`default_nettype none

module program_store #(
    parameter int PROG_ADDR_BITS = 10
) (
    input  logic                      i_clk,

    input  logic                      i_prog_we,
    input  logic [PROG_ADDR_BITS-1:0] i_prog_addr,
    input  logic [7:0]                i_prog_data,

    mem_bus_if.target_rd              bus
);

localparam int DEPTH = 2 ** PROG_ADDR_BITS;

logic [7:0] r_mem [0:DEPTH-1];

// load port from outside
always_ff @(posedge i_clk)
begin
    if (i_prog_we)
    begin
        r_mem[i_prog_addr] <= i_prog_data;
    end
end

// only the low bits decode, so the store repeats over all of 64K
// and the reset vector lands in the top four bytes
assign bus.rdata = r_mem[bus.addr[PROG_ADDR_BITS-1:0]];

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
    input  logic        i_clk,
    input  logic        i_reset_n,

    mem_bus_if.master   bus,

    output logic [15:0] o_debug_pc,
    output logic [7:0]  o_debug_a
);

localparam logic STATE_RESET_VECTOR = 1'b0;  // read PC from the vector
localparam logic STATE_EXECUTE      = 1'b1;  // fetch and execute opcodes

localparam logic RW_READ  = 1'b1;
localparam logic RW_WRITE = 1'b0;

localparam logic ADDR_MODE_PC  = 1'b0;       // r_pc drives the bus
localparam logic ADDR_MODE_ALT = 1'b1;       // r_address drives the bus

logic               r_state;
logic [1:0]         r_tcu;                   // cycle within the current step
logic [15:0]        r_pc;
logic [15:0]        r_address;               // vector or store target
logic               r_address_mode;
logic               r_rw;
logic [7:0]         r_wdata;
m6502_pkg::opcode_u r_ir;
logic [7:0]         r_a;
logic [7:0]         r_x;
logic [7:0]         r_y;

logic               cc_valid;
logic               is_load;
logic               is_store;
logic               is_jmp;
logic [7:0]         store_src;

// grouped decode on the aaa-bbb-cc fields
always_comb
begin
    cc_valid = (r_ir.f.cc == m6502_pkg::CC_A) ||
               (r_ir.f.cc == m6502_pkg::CC_X) ||
               (r_ir.f.cc == m6502_pkg::CC_Y);

    is_load = 1'b0;
    if (r_ir.f.aaa == m6502_pkg::AAA_LOAD)
    begin
        if (r_ir.f.cc == m6502_pkg::CC_A)
        begin
            is_load = (r_ir.f.bbb == m6502_pkg::BBB_IMM_A);
        end
        else if (cc_valid)
        begin
            is_load = (r_ir.f.bbb == m6502_pkg::BBB_IMM_XY);
        end
    end

    is_store = (r_ir.f.aaa == m6502_pkg::AAA_STORE) &&
               (r_ir.f.bbb == m6502_pkg::BBB_ABS) && cc_valid;

    is_jmp = (r_ir.raw == m6502_pkg::OP_JMP_ABS);  // exact byte match
end

// cc picks the register a store writes out
always_comb
begin
    case (r_ir.f.cc)
        m6502_pkg::CC_A: store_src = r_a;
        m6502_pkg::CC_X: store_src = r_x;
        default:         store_src = r_y;
    endcase
end

always_ff @(posedge i_clk)
begin
    if (!i_reset_n)
    begin
        r_state        <= STATE_RESET_VECTOR;
        r_tcu          <= 2'd0;
        r_pc           <= 16'h0000;
        r_address      <= m6502_pkg::RESET_VECTOR;
        r_address_mode <= ADDR_MODE_ALT;
        r_rw           <= RW_READ;
        r_wdata        <= 8'h00;
    end
    else if (r_state == STATE_RESET_VECTOR)
    begin
        r_tcu <= r_tcu + 2'd1;
        if (r_tcu == 2'd1)
        begin
            r_pc[7:0] <= bus.rdata;               // vector low byte
            r_address <= r_address + 16'd1;
        end
        else if (r_tcu == 2'd2)
        begin
            r_pc[15:8]     <= bus.rdata;          // vector high byte
            r_state        <= STATE_EXECUTE;
            r_address_mode <= ADDR_MODE_PC;
            r_tcu          <= 2'd0;
        end
    end
    else
    begin
        r_tcu <= r_tcu + 2'd1;
        case (r_tcu)
            2'd0:
            begin
                r_ir <= bus.rdata;                // opcode fetch
                r_pc <= r_pc + 16'd1;
            end
            2'd1:
            begin
                if (is_load)
                begin
                    case (r_ir.f.cc)
                        m6502_pkg::CC_A: r_a <= bus.rdata;
                        m6502_pkg::CC_X: r_x <= bus.rdata;
                        default:         r_y <= bus.rdata;
                    endcase
                    r_pc  <= r_pc + 16'd1;
                    r_tcu <= 2'd0;
                end
                else if (is_jmp || is_store)
                begin
                    r_address[7:0] <= bus.rdata;  // operand low byte
                    r_pc           <= r_pc + 16'd1;
                end
                else
                begin
                    r_tcu <= 2'd0;                // NOP and unknown, dummy cycle
                end
            end
            2'd2:
            begin
                if (is_jmp)
                begin
                    r_pc  <= {bus.rdata, r_address[7:0]};
                    r_tcu <= 2'd0;
                end
                else
                begin
                    r_address[15:8] <= bus.rdata; // store target high byte
                    r_pc            <= r_pc + 16'd1;
                    r_address_mode  <= ADDR_MODE_ALT;
                    r_rw            <= RW_WRITE;
                    r_wdata         <= store_src;
                end
            end
            default:
            begin
                // write cycle done, back to PC
                r_address_mode <= ADDR_MODE_PC;
                r_rw           <= RW_READ;
                r_wdata        <= 8'h00;
                r_tcu          <= 2'd0;
            end
        endcase
    end
end

assign bus.addr  = (r_address_mode == ADDR_MODE_PC) ? r_pc : r_address;
assign bus.rw    = r_rw;
assign bus.wdata = r_wdata;

assign o_debug_pc = r_pc;
assign o_debug_a  = r_a;

endmodule

`default_nettype wire

/* hw/io_port.sv */
`timescale 1ns/10ps
`default_nettype none

module io_port (
    input  logic                                i_clk,
    input  logic                                i_reset_n,

    mem_bus_if.target_wr                        bus,

    output logic                                o_port_strobe,
    output logic [soc_map_pkg::IO_INDEX_BITS-1:0] o_port_index,
    output logic [7:0]                          o_port_data
);

logic io_hit;

// write cycle inside the I/O window
assign io_hit = !bus.rw &&
                ((bus.addr & soc_map_pkg::IO_MASK) == soc_map_pkg::IO_BASE);

always_ff @(posedge i_clk)
begin
    if (!i_reset_n)
    begin
        o_port_strobe <= 1'b0;
        o_port_index  <= '0;
        o_port_data   <= 8'h00;
    end
    else
    begin
        o_port_strobe <= io_hit;    // one cycle per write
        if (io_hit)
        begin
            o_port_index <= bus.addr[soc_map_pkg::IO_INDEX_BITS-1:0];
            o_port_data  <= bus.wdata;  // held until next hit
        end
    end
end

endmodule

`default_nettype wire

/* hw/soc6502_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc6502_top #(
    parameter int PROG_ADDR_BITS = 10
) (
    input  logic                                  i_clk,
    input  logic                                  i_reset_n,

    // program load port
    input  logic                                  i_prog_we,
    input  logic [PROG_ADDR_BITS-1:0]             i_prog_addr,
    input  logic [7:0]                            i_prog_data,

    // output port
    output logic                                  o_port_strobe,
    output logic [soc_map_pkg::IO_INDEX_BITS-1:0] o_port_index,
    output logic [7:0]                            o_port_data,

    output logic [15:0]                           o_debug_pc,
    output logic [7:0]                            o_debug_a
);

mem_bus_if bus_if ();                 // shared byte bus

program_store #(
    .PROG_ADDR_BITS (PROG_ADDR_BITS)
) u_program_store (
    .i_clk       (i_clk),
    .i_prog_we   (i_prog_we),
    .i_prog_addr (i_prog_addr),
    .i_prog_data (i_prog_data),
    .bus         (bus_if.target_rd)
);

cpu_core u_cpu_core (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .bus        (bus_if.master),
    .o_debug_pc (o_debug_pc),
    .o_debug_a  (o_debug_a)
);

io_port u_io_port (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .bus           (bus_if.target_wr),
    .o_port_strobe (o_port_strobe),
    .o_port_index  (o_port_index),
    .o_port_data   (o_port_data)
);

endmodule

`default_nettype wire

/* testbench/soc6502_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module soc6502_assert (
    input  logic        i_clk,
    input  logic        i_reset_n,
    input  logic        i_port_strobe,
    input  logic [15:0] i_bus_addr,
    input  logic        i_bus_rw
);

int   fail_count = 0;   // failed assertions so far
logic io_write;

assign io_write = !i_bus_rw &&
                  ((i_bus_addr & soc_map_pkg::IO_MASK) == soc_map_pkg::IO_BASE);

a_strobe_one_cycle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_port_strobe |=> !i_port_strobe)
else
begin
    fail_count++;
    $error("port strobe stayed high for two cycles");
end

a_strobe_low_after_reset: assert property (@(posedge i_clk)
    !i_reset_n |=> !i_port_strobe)
else
begin
    fail_count++;
    $error("port strobe high in the first cycle after reset");
end

a_write_gives_strobe: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    io_write |=> i_port_strobe)
else
begin
    fail_count++;
    $error("I/O window write not followed by a port strobe");
end

endmodule

bind soc6502_top soc6502_assert u_soc_assert (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_port_strobe (o_port_strobe),
    .i_bus_addr    (bus_if.addr),
    .i_bus_rw      (bus_if.rw)
);

`default_nettype wire

/* testbench/tb_soc6502.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc6502;

localparam int PROG_ADDR_BITS   = 10;
localparam int RESET_SEQ_CYCLES = 3;    // vector read before the first fetch
localparam int STROBE_LIMIT     = 40;

logic                                  i_clk;
logic                                  i_reset_n;
logic                                  i_prog_we;
logic [PROG_ADDR_BITS-1:0]             i_prog_addr;
logic [7:0]                            i_prog_data;
logic                                  o_port_strobe;
logic [soc_map_pkg::IO_INDEX_BITS-1:0] o_port_index;
logic [7:0]                            o_port_data;
logic [15:0]                           o_debug_pc;
logic [7:0]                            o_debug_a;

logic [15:0] img_addr [$];              // program image, address and byte
logic [7:0]  img_data [$];
logic [15:0] cursor;
logic [15:0] entry;                     // goes into the reset vector
string       test_name;
int          cycle_idx;                 // 0 is the cycle of reset release
int          errors;
int          errors_at_start;
int          tests_run;
int          tests_failed;

soc6502_top #(
    .PROG_ADDR_BITS (PROG_ADDR_BITS)
) i_dut (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_prog_we     (i_prog_we),
    .i_prog_addr   (i_prog_addr),
    .i_prog_data   (i_prog_data),
    .o_port_strobe (o_port_strobe),
    .o_port_index  (o_port_index),
    .o_port_data   (o_port_data),
    .o_debug_pc    (o_debug_pc),
    .o_debug_a     (o_debug_a)
);

initial
begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
end

task automatic check_value(input string what, input int expected, input int actual);
    if (expected != actual)
    begin
        errors++;
        $display("** Error %s: %s expected 0x%0h, actual 0x%0h",
                 test_name, what, expected, actual);
    end
endtask

function automatic logic [7:0] field_op(input logic [2:0] aaa, input logic [2:0] bbb,
                                        input logic [1:0] cc);
    m6502_pkg::opcode_u op;
    op.f.aaa = aaa;
    op.f.bbb = bbb;
    op.f.cc  = cc;
    return op.raw;
endfunction

task automatic emit(input logic [7:0] data);
    img_addr.push_back(cursor);
    img_data.push_back(data);
    cursor = cursor + 16'd1;
endtask

task automatic emit_abs(input logic [7:0] op, input logic [15:0] target);
    emit(op);
    emit(target[7:0]);
    emit(target[15:8]);
endtask

task automatic park();
    emit_abs(m6502_pkg::OP_JMP_ABS, cursor);  // jump to itself
endtask

task automatic new_program(input logic [15:0] origin);
    img_addr.delete();
    img_data.delete();
    cursor = origin;
    entry  = origin;
endtask

task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
    @(posedge i_clk);
    i_prog_we   <= 1'b1;
    i_prog_addr <= addr[PROG_ADDR_BITS-1:0];   // store mirrors every 1K
    i_prog_data <= data;
endtask

// hold reset, load vector and image, then let the core run
task automatic run_program();
    @(posedge i_clk);
    i_reset_n <= 1'b0;
    repeat (2) @(posedge i_clk);
    write_byte(m6502_pkg::RESET_VECTOR, entry[7:0]);
    write_byte(m6502_pkg::RESET_VECTOR + 16'd1, entry[15:8]);
    foreach (img_addr[i])
    begin
        write_byte(img_addr[i], img_data[i]);
    end
    @(posedge i_clk);
    i_prog_we <= 1'b0;
    @(posedge i_clk);
    i_reset_n <= 1'b1;
    cycle_idx = -1;
endtask

task automatic wait_for_strobe(input int limit, output bit seen);
    int waited;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < limit)
    begin
        @(negedge i_clk);
        cycle_idx++;
        waited++;
        seen = (o_port_strobe === 1'b1);
    end
endtask

task automatic expect_strobe(input int index, input int data);
    bit seen;
    wait_for_strobe(STROBE_LIMIT, seen);
    if (!seen)
    begin
        errors++;
        $display("%s: timed out waiting for a port strobe", test_name);
    end
    else
    begin
        check_value("port index", index, o_port_index);
        check_value("port data", data, o_port_data);
    end
endtask

task automatic expect_quiet(input int limit);
    bit seen;
    wait_for_strobe(limit, seen);
    if (seen)
    begin
        errors++;
        $display("%s: unexpected port strobe at index %0d", test_name, o_port_index);
    end
endtask

task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
endtask

task automatic end_test();
    tests_run++;
    if (errors == errors_at_start)
    begin
        $display("test %s passed", test_name);
    end
    else
    begin
        tests_failed++;
        $display("test %s failed with %0d errors", test_name, errors - errors_at_start);
    end
endtask

task automatic test_lda_sta();
    logic [7:0] v;
    v = 8'($urandom);
    begin_test("lda_sta");
    new_program(16'h0100);
    emit(m6502_pkg::OP_LDA_IMM);
    emit(v);
    emit_abs(m6502_pkg::OP_STA_ABS, 16'hD003);
    park();
    run_program();
    expect_strobe(3, v);
    expect_quiet(12);
    end_test();
endtask

task automatic test_x_y();
    logic [7:0] p;
    logic [7:0] q;
    p = 8'($urandom);
    q = 8'($urandom);
    begin_test("x_y");
    new_program(16'h0200);
    emit(field_op(m6502_pkg::AAA_LOAD, m6502_pkg::BBB_IMM_XY, m6502_pkg::CC_X));
    emit(p);
    emit(field_op(m6502_pkg::AAA_LOAD, m6502_pkg::BBB_IMM_XY, m6502_pkg::CC_Y));
    emit(q);
    emit_abs(field_op(m6502_pkg::AAA_STORE, m6502_pkg::BBB_ABS, m6502_pkg::CC_X), 16'hD001);
    emit_abs(field_op(m6502_pkg::AAA_STORE, m6502_pkg::BBB_ABS, m6502_pkg::CC_Y), 16'hD00E);
    park();
    run_program();
    expect_strobe(1, p);
    expect_strobe(14, q);
    end_test();
endtask

task automatic test_jmp();
    logic [7:0] good;
    good = 8'($urandom);
    begin_test("jmp");
    new_program(16'h0100);
    emit(m6502_pkg::OP_LDA_IMM);
    emit(good);
    emit_abs(m6502_pkg::OP_JMP_ABS, 16'h0140);
    emit(m6502_pkg::OP_LDA_IMM);          // skipped code with a wrong value
    emit(~good);
    emit_abs(m6502_pkg::OP_STA_ABS, 16'hD007);
    cursor = 16'h0140;
    emit_abs(m6502_pkg::OP_STA_ABS, 16'hD005);
    park();
    run_program();
    expect_strobe(5, good);
    expect_quiet(16);
    end_test();
endtask

task automatic test_nop_unknown();
    logic [7:0] v;
    v = 8'($urandom);
    begin_test("nop_unknown");
    new_program(16'h0180);
    emit(m6502_pkg::OP_NOP);
    emit(8'h02);
    emit(8'hFF);
    emit(m6502_pkg::OP_NOP);
    emit(m6502_pkg::OP_LDA_IMM);
    emit(v);
    emit_abs(m6502_pkg::OP_STA_ABS, 16'hD009);
    park();
    run_program();
    expect_strobe(9, v);
    end_test();
endtask

task automatic test_window();
    logic [15:0] addr;
    logic [7:0]  v;
    logic [7:0]  marker;
    bit          hit;
    begin_test("window");
    for (int i = 0; i < 20; i++)
    begin
        addr   = 16'($urandom);
        v      = 8'($urandom);
        marker = 8'($urandom);
        if ($urandom % 2 == 0)
        begin
            addr = soc_map_pkg::IO_BASE | {12'h000, addr[3:0]};  // force a hit
        end
        hit = ((addr & soc_map_pkg::IO_MASK) == soc_map_pkg::IO_BASE);
        new_program(16'h0100);
        emit(m6502_pkg::OP_LDA_IMM);
        emit(v);
        emit_abs(m6502_pkg::OP_STA_ABS, addr);
        emit(m6502_pkg::OP_LDA_IMM);
        emit(marker);
        emit_abs(m6502_pkg::OP_STA_ABS, 16'hD00F);   // progress marker
        park();
        run_program();
        if (hit)
        begin
            expect_strobe(addr[3:0], v);
        end
        else
        begin
            expect_quiet(12);             // marker strobe is due in cycle 15
        end
        expect_strobe(15, marker);
    end
    end_test();
endtask

task automatic test_latency();
    logic [7:0]  v;
    logic [15:0] park_addr;
    bit          seen;
    int          fetch_cycle;
    v = 8'($urandom);
    begin_test("latency");
    new_program(16'h0100);
    emit(m6502_pkg::OP_NOP);
    emit(m6502_pkg::OP_LDA_IMM);
    emit(v);
    emit_abs(m6502_pkg::OP_STA_ABS, 16'hD005);
    park_addr = cursor;                      // fetched in the strobe cycle
    park();
    fetch_cycle = RESET_SEQ_CYCLES + 2 + 2;  // after NOP and LDA
    run_program();
    wait_for_strobe(STROBE_LIMIT, seen);
    if (!seen)
    begin
        errors++;
        $display("%s: timed out waiting for a port strobe", test_name);
    end
    else
    begin
        check_value("strobe cycle", fetch_cycle + 4, cycle_idx);
        check_value("port data", v, o_port_data);
        check_value("debug a", v, o_debug_a);
        check_value("debug pc", park_addr, o_debug_pc);
    end
    end_test();
endtask

initial
begin
    i_reset_n    = 1'b0;
    i_prog_we    = 1'b0;
    i_prog_addr  = '0;
    i_prog_data  = 8'h00;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_idx    = 0;
    void'($urandom(32'h5fdc));
    repeat (2) @(posedge i_clk);
    test_lda_sta();
    test_x_y();
    test_jmp();
    test_nop_unknown();
    test_window();
    test_latency();
    $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, i_dut.u_soc_assert.fail_count);
    if (tests_failed == 0 && errors == 0 && i_dut.u_soc_assert.fail_count == 0)
    begin
        $display("SIMULATION PASSED");
    end
    else
    begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

/* soc6502.f */
hw/m6502_pkg.sv
hw/soc_map_pkg.sv
hw/mem_bus_if.sv
hw/program_store.sv
hw/cpu_core.sv
hw/io_port.sv
hw/soc6502_top.sv
testbench/soc6502_assert.sv
testbench/tb_soc6502.sv

/* Bender.yml */
package:
  name: soc6502

sources:
  # packages and the bus interface come first
  - hw/m6502_pkg.sv
  - hw/soc_map_pkg.sv
  - hw/mem_bus_if.sv
  - hw/program_store.sv
  - hw/cpu_core.sv
  - hw/io_port.sv
  - hw/soc6502_top.sv

  - target: simulation
    files:
      - testbench/soc6502_assert.sv
      - testbench/tb_soc6502.sv
